// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := periph_bus_tb
FILELIST := sources.f

BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))
HDRS      := $(wildcard common/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/periph_cfg.svh ====
// Bus geometry, slot assignments and UART reset values, included by the bus RTL
`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// CPU side address width
`define PERI_ADDR_W 11

// Output pins routed through the function selects
`define PERI_NUM_PINS 8

// User slot positions of the full peripherals
`define PERI_SLOT_GPIO 1
`define PERI_SLOT_UART_TX 2

// Byte slots 0 up to this count hold scratch peripherals
`define PERI_NUM_SCRATCH 2

// Clocks per UART bit after reset
`define UART_DIV_RESET 16'd4

`endif

// ==== common/periph_pkg.sv ====
// Shared bus types for the peripheral bus, referenced by scoped name from RTL and testbench
package periph_pkg;

    // Size code on the CPU request port, ACC_NONE means no access
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_NONE = 2'b11
    } access_size_t;

    // Source of one output pin
    // simple picks the byte slots, otherwise the user slots
    typedef struct packed {
        logic       simple;
        logic [3:0] slot;
    } func_sel_t;

endpackage

// ==== logic/byte_scratch.sv ====
// Byte slot scratch peripheral with four registers, register 0 drives the output pins
`timescale 1ns/1ps

module byte_scratch (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] i_addr,
    input  logic       i_write,
    input  logic [7:0] i_data,
    output logic [7:0] o_data,
    output logic [7:0] o_pins
);

    logic [3:0][7:0] regs;
    logic            in_range;

    // Only offsets 0 to 3 hold registers
    assign in_range = (i_addr[3:2] == 2'b00);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (i_write && in_range) begin
            regs[i_addr[1:0]] <= i_data;
        end
    end

    assign o_data = in_range ? regs[i_addr[1:0]] : 8'h00;
    assign o_pins = regs[0];

endmodule

// ==== periph/gpio_ctrl.sv ====
// GPIO peripheral: output register, input readback and per-pin function selects for the bus
`timescale 1ns/1ps
`include "periph_cfg.svh"

module gpio_ctrl (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic [5:0]                                 i_addr,
    input  logic [31:0]                                i_data,
    input  periph_pkg::access_size_t                   i_write_n,
    input  periph_pkg::access_size_t                   i_read_n,
    input  logic [`PERI_NUM_PINS-1:0]                  i_ui_in,
    output logic [31:0]                                o_data,
    output logic [`PERI_NUM_PINS-1:0]                  o_pins,
    output periph_pkg::func_sel_t [`PERI_NUM_PINS-1:0] o_func_sel
);

    logic                                       wr_en;
    logic                                       rd_en;
    logic                                       sel_hit;
    logic [`PERI_NUM_PINS-1:0]                  gpio_out;
    periph_pkg::func_sel_t [`PERI_NUM_PINS-1:0] func_sel_q;

    assign wr_en = (i_write_n != periph_pkg::ACC_NONE);
    assign rd_en = (i_read_n != periph_pkg::ACC_NONE);

    // Function selects sit at 0x20-0x3C, one word per pin
    assign sel_hit = i_addr[5] && (i_addr[1:0] == 2'b00);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            // Pin 0 carries UART TX, the rest start on GPIO
            for (int p = 0; p < `PERI_NUM_PINS; p++) begin
                func_sel_q[p].simple <= 1'b0;
                func_sel_q[p].slot   <= (p == 0) ? 4'(`PERI_SLOT_UART_TX)
                                                 : 4'(`PERI_SLOT_GPIO);
            end
        end else if (wr_en) begin
            if (i_addr == 6'h00) begin
                gpio_out <= i_data[`PERI_NUM_PINS-1:0];
            end
            if (sel_hit) begin
                func_sel_q[i_addr[4:2]] <= periph_pkg::func_sel_t'(i_data[4:0]);
            end
        end
    end

    always_comb begin
        o_data = '0;
        if (rd_en) begin
            if (i_addr == 6'h00) begin
                o_data = 32'(gpio_out);
            end else if (i_addr == 6'h04) begin
                o_data = 32'(i_ui_in);
            end else if (sel_hit) begin
                o_data = {27'h0, func_sel_q[i_addr[4:2]]};
            end
        end
    end

    assign o_pins     = gpio_out;
    assign o_func_sel = func_sel_q;

endmodule

// ==== periph/periph_bus.sv ====
// Peripheral bus top: decodes CPU accesses to the slots, holds read data and routes output pins
`timescale 1ns/1ps
`include "periph_cfg.svh"

module periph_bus (
    input  logic                           clk,
    input  logic                           rst_n,

    input  logic [`PERI_NUM_PINS-1:0]      i_ui_in,
    output logic [`PERI_NUM_PINS-1:0]      o_uo_out,

    input  logic [`PERI_ADDR_W-1:0]        i_addr,
    input  logic [31:0]                    i_data,
    input  periph_pkg::access_size_t       i_write_n,
    input  periph_pkg::access_size_t       i_read_n,

    output logic [31:0]                    o_data,
    output logic                           o_data_ready,
    input  logic                           i_read_complete,

    output logic                           o_interrupt
);

    logic        read_req;
    logic        write_req;
    logic        last_read_req;
    logic        data_hold;
    logic        data_ready_r;
    logic [31:0] data_r;

    // Selected slot, straight from the decode
    logic [15:0] user_sel;
    logic [15:0] byte_sel;
    logic [31:0] peri_data;
    logic        peri_ready;

    logic [31:0]               user_data  [16];
    logic                      user_ready [16];
    logic [`PERI_NUM_PINS-1:0] user_pins  [16];
    logic [7:0]                byte_data  [16];
    logic [`PERI_NUM_PINS-1:0] byte_pins  [16];

    periph_pkg::func_sel_t [`PERI_NUM_PINS-1:0] func_sel;

    periph_pkg::access_size_t gpio_write_n;
    periph_pkg::access_size_t gpio_read_n;
    periph_pkg::access_size_t uart_write_n;
    periph_pkg::access_size_t uart_read_n;

    assign read_req  = (i_read_n != periph_pkg::ACC_NONE);
    assign write_req = (i_write_n != periph_pkg::ACC_NONE);

    // Bit 10 switches between byte slots (16 bytes) and user slots (64 bytes)
    always_comb begin
        user_sel = '0;
        byte_sel = '0;
        if (i_addr[10]) begin
            byte_sel[i_addr[7:4]] = 1'b1;
            peri_data  = {24'h0, byte_data[i_addr[7:4]]};
            peri_ready = 1'b1;
        end else begin
            user_sel[i_addr[9:6]] = 1'b1;
            peri_data  = user_data[i_addr[9:6]];
            peri_ready = user_ready[i_addr[9:6]];
        end
    end

    // Capture once per read and keep it until the CPU signals completion
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_hold     <= 1'b0;
            last_read_req <= 1'b0;
            data_ready_r  <= 1'b0;
        end else begin
            if (i_read_complete) begin
                data_hold <= 1'b0;
            end
            if (!data_hold && peri_ready && read_req) begin
                data_hold <= 1'b1;
            end
            last_read_req <= read_req;
            // Ready lines up with the registered data
            data_ready_r  <= last_read_req && read_req && peri_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (!data_hold && peri_ready && read_req) begin
            data_r <= peri_data;
        end
    end

    assign o_data       = data_r;
    assign o_data_ready = (data_ready_r && read_req) || write_req;

    // Unselected full peripherals see no access
    assign gpio_write_n = user_sel[`PERI_SLOT_GPIO] ? i_write_n : periph_pkg::ACC_NONE;
    assign gpio_read_n  = user_sel[`PERI_SLOT_GPIO] ? i_read_n : periph_pkg::ACC_NONE;
    assign uart_write_n = user_sel[`PERI_SLOT_UART_TX] ? i_write_n : periph_pkg::ACC_NONE;
    assign uart_read_n  = user_sel[`PERI_SLOT_UART_TX] ? i_read_n : periph_pkg::ACC_NONE;

    gpio_ctrl u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_addr     (i_addr[5:0]),
        .i_data     (i_data),
        .i_write_n  (gpio_write_n),
        .i_read_n   (gpio_read_n),
        .i_ui_in    (i_ui_in),
        .o_data     (user_data[`PERI_SLOT_GPIO]),
        .o_pins     (user_pins[`PERI_SLOT_GPIO]),
        .o_func_sel (func_sel)
    );

    uart_tx u_uart_tx (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_addr      (i_addr[5:0]),
        .i_data      (i_data),
        .i_write_n   (uart_write_n),
        .i_read_n    (uart_read_n),
        .o_data      (user_data[`PERI_SLOT_UART_TX]),
        .o_pins      (user_pins[`PERI_SLOT_UART_TX]),
        .o_interrupt (o_interrupt)
    );

    // Empty user slots still answer so a stray read returns zero
    for (genvar s = 0; s < 16; s++) begin : g_user
        assign user_ready[s] = 1'b1;
        if (s != `PERI_SLOT_GPIO && s != `PERI_SLOT_UART_TX) begin : g_empty
            assign user_data[s] = '0;
            assign user_pins[s] = '0;
        end
    end

    for (genvar s = 0; s < 16; s++) begin : g_byte
        if (s < `PERI_NUM_SCRATCH) begin : g_scratch
            byte_scratch u_scratch (
                .clk     (clk),
                .rst_n   (rst_n),
                .i_addr  (i_addr[3:0]),
                .i_write (write_req && byte_sel[s]),
                .i_data  (i_data[7:0]),
                .o_data  (byte_data[s]),
                .o_pins  (byte_pins[s])
            );
        end else begin : g_empty
            assign byte_data[s] = '0;
            assign byte_pins[s] = '0;
        end
    end

    // Pin i takes bit i of whichever peripheral its select names
    for (genvar p = 0; p < `PERI_NUM_PINS; p++) begin : g_pin
        assign o_uo_out[p] = func_sel[p].simple ? byte_pins[func_sel[p].slot][p]
                                                : user_pins[func_sel[p].slot][p];
    end

endmodule

// ==== periph/uart_tx.sv ====
// UART transmitter peripheral with programmable bit divider and frame done interrupt
`timescale 1ns/1ps
`include "periph_cfg.svh"

module uart_tx (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [5:0]               i_addr,
    input  logic [31:0]              i_data,
    input  periph_pkg::access_size_t i_write_n,
    input  periph_pkg::access_size_t i_read_n,
    output logic [31:0]              o_data,
    output logic [7:0]               o_pins,
    output logic                     o_interrupt
);

    logic        wr_en;
    logic        rd_en;
    logic        load;
    logic        bit_end;
    logic        busy;
    logic        irq;
    logic [15:0] divider;
    logic [15:0] bit_cnt;
    logic [3:0]  bit_idx;
    // Stop, data and start bits, sent from bit 0 upwards
    logic [9:0]  shift_q;

    assign wr_en   = (i_write_n != periph_pkg::ACC_NONE);
    assign rd_en   = (i_read_n != periph_pkg::ACC_NONE);
    assign load    = wr_en && !busy && (i_addr == 6'h00);
    assign bit_end = (bit_cnt + 16'd1) >= divider;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            irq     <= 1'b0;
            divider <= `UART_DIV_RESET;
            bit_cnt <= '0;
            bit_idx <= '0;
        end else begin
            if (wr_en && i_addr == 6'h08) begin
                divider <= i_data[15:0];
            end
            if (wr_en && i_addr == 6'h04) begin
                irq <= 1'b0;
            end
            if (busy) begin
                if (bit_end) begin
                    bit_cnt <= '0;
                    // Frame ends with the stop bit
                    if (bit_idx == 4'd9) begin
                        busy <= 1'b0;
                        irq  <= 1'b1;
                    end else begin
                        bit_idx <= bit_idx + 4'd1;
                    end
                end else begin
                    bit_cnt <= bit_cnt + 16'd1;
                end
            end else if (load) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
                bit_idx <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= {1'b1, i_data[7:0], 1'b0};
        end else if (busy && bit_end) begin
            shift_q <= {1'b1, shift_q[9:1]};
        end
    end

    always_comb begin
        o_data = '0;
        if (rd_en) begin
            if (i_addr == 6'h00) begin
                o_data = {31'h0, busy};
            end else if (i_addr == 6'h08) begin
                o_data = {16'h0, divider};
            end
        end
    end

    // Line idles high between frames
    assign o_pins      = {7'h0, busy ? shift_q[0] : 1'b1};
    assign o_interrupt = irq;

endmodule

// ==== sources.f ====
+incdir+common
common/periph_pkg.sv
logic/byte_scratch.sv
periph/gpio_ctrl.sv
periph/uart_tx.sv
periph/periph_bus.sv
test/periph_bus_assertions.sv
test/periph_bus_tb.sv

// ==== test/periph_bus_assertions.sv ====
// Concurrent checks on the bus handshake and UART interrupt that are bound into the bus top
`timescale 1ns/1ps
`include "periph_cfg.svh"

module periph_bus_assertions (
    input logic                     clk,
    input logic                     rst_n,
    input logic [`PERI_ADDR_W-1:0]  i_addr,
    input periph_pkg::access_size_t i_write_n,
    input periph_pkg::access_size_t i_read_n,
    input logic [31:0]              i_data_out,
    input logic                     i_data_ready,
    input logic                     i_read_complete,
    input logic                     i_interrupt
);

    int   error_count = 0;
    logic read_req;
    logic write_req;
    logic uart_wr;
    logic irq_clear;
    logic tx_started;

    assign read_req  = (i_read_n != periph_pkg::ACC_NONE);
    assign write_req = (i_write_n != periph_pkg::ACC_NONE);
    assign uart_wr   = write_req && !i_addr[10] && (i_addr[9:6] == 4'(`PERI_SLOT_UART_TX));
    assign irq_clear = uart_wr && (i_addr[5:0] == 6'h04);

    // Set once a byte has been handed to the transmitter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_started <= 1'b0;
        end else if (uart_wr && i_addr[5:0] == 6'h00) begin
            tx_started <= 1'b1;
        end
    end

    // Read ready comes only after two request cycles and write ready needs a write
    a_ready_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(i_data_ready) |->
            write_req || (read_req && $past(read_req) && $past(read_req, 2)))
        else begin
            error_count++;
            $error("o_data_ready rose without a write or two read request cycles");
        end

    a_irq_after_frame: assert property (@(posedge clk) disable iff (!rst_n)
        !tx_started |-> !i_interrupt)
        else begin
            error_count++;
            $error("o_interrupt high before any UART frame");
        end

    a_irq_clear: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(i_interrupt) |-> $past(irq_clear))
        else begin
            error_count++;
            $error("o_interrupt dropped without a write to offset 4");
        end

    a_read_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (read_req && !write_req && i_data_ready && !i_read_complete) |=> $stable(i_data_out))
        else begin
            error_count++;
            $error("o_data changed while a read was held");
        end

endmodule

bind periph_bus periph_bus_assertions u_assert (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_addr          (i_addr),
    .i_write_n       (i_write_n),
    .i_read_n        (i_read_n),
    .i_data_out      (o_data),
    .i_data_ready    (o_data_ready),
    .i_read_complete (i_read_complete),
    .i_interrupt     (o_interrupt)
);

// ==== test/periph_bus_tb.sv ====
// Table-driven testbench that runs as the simulation top and drives the peripheral bus
`timescale 1ns/1ps

module periph_bus_tb;

    localparam int MAX_ENTRIES = 64;
    localparam int UART_DIV    = 6;
    localparam int READ_WAIT   = 20;

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_UI, OP_PIN, OP_UART, OP_HOLD} op_t;

    logic                     clk;
    logic                     rst_n;
    logic [7:0]               ui_in;
    logic [7:0]               uo_out;
    logic [10:0]              addr;
    logic [31:0]              wdata;
    periph_pkg::access_size_t write_n;
    periph_pkg::access_size_t read_n;
    logic [31:0]              rdata;
    logic                     data_ready;
    logic                     read_complete;
    logic                     interrupt;

    op_t         tbl_op   [MAX_ENTRIES];
    int          tbl_grp  [MAX_ENTRIES];
    logic [10:0] tbl_addr [MAX_ENTRIES];
    logic [31:0] tbl_data [MAX_ENTRIES];
    logic [31:0] tbl_exp  [MAX_ENTRIES];
    int          n_entries;
    logic        table_ready = 1'b0;
    logic [31:0] rng;
    int          checks;
    int          errors;
    int          grp_errors;
    int          assert_errors;

    periph_bus dut0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (ui_in),
        .o_uo_out        (uo_out),
        .i_addr          (addr),
        .i_data          (wdata),
        .i_write_n       (write_n),
        .i_read_n        (read_n),
        .o_data          (rdata),
        .o_data_ready    (data_ready),
        .i_read_complete (read_complete),
        .o_interrupt     (interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic string test_name(input int grp);
        case (grp)
            1: return "GPIO";
            2: return "byte slots";
            3: return "pin routing";
            4: return "UART";
            default: return "handshake";
        endcase
    endfunction

    task automatic next_byte(output logic [7:0] v);
        rng = xorshift(rng);
        v = rng[7:0];
    endtask

    task automatic add_entry(input int grp, input op_t op, input logic [10:0] a,
                             input logic [31:0] d, input logic [31:0] e);
        tbl_grp[n_entries]  = grp;
        tbl_op[n_entries]   = op;
        tbl_addr[n_entries] = a;
        tbl_data[n_entries] = d;
        tbl_exp[n_entries]  = e;
        n_entries++;
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            grp_errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Register map has GPIO at 0x040, UART at 0x080 and byte slots at 0x4s0
    task automatic build_table();
        logic [7:0] g;
        logic [7:0] u;
        logic [7:0] v;
        logic [7:0] x;
        logic [7:0] b [2][4];
        n_entries = 0;
        rng = 32'h48f1;
        for (int k = 0; k < 2; k++) begin
            next_byte(g);
            next_byte(u);
            add_entry(1, OP_WR, 11'h040, {24'h0, g}, 32'h0);
            add_entry(1, OP_RD, 11'h040, 32'h0, {24'h0, g});
            // Pin 0 still shows the idle UART line
            add_entry(1, OP_PIN, 11'h000, 32'h0, {24'h0, g[7:1], 1'b1});
            add_entry(1, OP_UI, 11'h000, {24'h0, u}, 32'h0);
            add_entry(1, OP_RD, 11'h044, 32'h0, {24'h0, u});
        end
        for (int s = 0; s < 2; s++) begin
            for (int r = 0; r < 4; r++) begin
                next_byte(b[s][r]);
                add_entry(2, OP_WR, {3'b100, 4'(s), 4'(r)}, {24'h0, b[s][r]}, 32'h0);
            end
        end
        for (int s = 0; s < 2; s++) begin
            for (int r = 0; r < 4; r++) begin
                add_entry(2, OP_RD, {3'b100, 4'(s), 4'(r)}, 32'h0, {24'h0, b[s][r]});
            end
        end
        add_entry(2, OP_RD, 11'h404, 32'h0, 32'h0);
        add_entry(2, OP_RD, 11'h140, 32'h0, 32'h0);
        add_entry(2, OP_RD, 11'h470, 32'h0, 32'h0);
        // Pin 3 to byte slot 1, pin 0 to GPIO
        add_entry(3, OP_WR, 11'h06C, 32'h11, 32'h0);
        add_entry(3, OP_WR, 11'h060, 32'h01, 32'h0);
        add_entry(3, OP_RD, 11'h06C, 32'h0, 32'h11);
        add_entry(3, OP_RD, 11'h060, 32'h0, 32'h01);
        add_entry(3, OP_RD, 11'h064, 32'h0, 32'h01);
        add_entry(3, OP_PIN, 11'h000, 32'h0, {24'h0, g[7:4], b[1][0][3], g[2:0]});
        // Pin 0 back on the UART for the frame test
        add_entry(3, OP_WR, 11'h060, 32'h02, 32'h0);
        add_entry(3, OP_RD, 11'h060, 32'h0, 32'h02);
        next_byte(x);
        add_entry(4, OP_WR, 11'h088, 32'(UART_DIV), 32'h0);
        add_entry(4, OP_RD, 11'h088, 32'h0, 32'(UART_DIV));
        add_entry(4, OP_UART, 11'h080, {24'h0, x}, {24'h0, x});
        next_byte(v);
        add_entry(5, OP_HOLD, 11'h044, {24'h0, v}, {24'h0, u});
        add_entry(5, OP_RD, 11'h044, 32'h0, {24'h0, v});
    endtask

    task automatic write_word(input logic [10:0] a, input logic [31:0] d);
        @(posedge clk);
        addr    <= a;
        wdata   <= d;
        write_n <= a[10] ? periph_pkg::ACC_BYTE : periph_pkg::ACC_WORD;
        @(negedge clk);
        check_value("o_data_ready", {31'h0, data_ready}, 32'h1);
        @(posedge clk);
        write_n <= periph_pkg::ACC_NONE;
    endtask

    // With hold set, i_ui_in changes while the read stays open
    task automatic read_check(input logic [10:0] a, input logic [31:0] exp,
                              input logic hold, input logic [7:0] ui_next);
        int edges;
        edges = 0;
        @(posedge clk);
        addr   <= a;
        read_n <= periph_pkg::ACC_WORD;
        // Rising edges counted from the start of the request until ready shows
        @(negedge clk);
        while (!data_ready && edges < READ_WAIT) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        checks++;
        assert (data_ready) else begin
            errors++;
            grp_errors++;
            $display("Read at address %h never saw o_data_ready", a);
        end
        check_value("ready edges", 32'(edges), 32'd2);
        check_value("o_data", rdata, exp);
        if (hold) begin
            @(posedge clk);
            ui_in <= ui_next;
            repeat (3) begin
                @(negedge clk);
                check_value("o_data held", rdata, exp);
            end
        end
        @(posedge clk);
        read_complete <= 1'b1;
        read_n        <= periph_pkg::ACC_NONE;
        @(posedge clk);
        read_complete <= 1'b0;
    endtask

    task automatic run_uart_test(input logic [7:0] x);
        logic [9:0] frame;
        frame = {1'b1, x, 1'b0};
        write_word(11'h080, {24'h0, x});
        fork
            begin
                // Sample the line in the middle of each bit
                repeat (UART_DIV / 2) @(posedge clk);
                for (int k = 0; k < 10; k++) begin
                    @(negedge clk);
                    check_value("o_uo_out[0]", {31'h0, uo_out[0]}, {31'h0, frame[k]});
                    if (k == 9) begin
                        check_value("o_interrupt", {31'h0, interrupt}, 32'h0);
                    end
                    repeat (UART_DIV) @(posedge clk);
                end
            end
            read_check(11'h080, 32'h1, 1'b0, 8'h00);
        join
        @(negedge clk);
        check_value("o_interrupt", {31'h0, interrupt}, 32'h1);
        write_word(11'h084, 32'h0);
        @(negedge clk);
        check_value("o_interrupt", {31'h0, interrupt}, 32'h0);
        read_check(11'h080, 32'h0, 1'b0, 8'h00);
    endtask

    initial begin
        wait (table_ready);
        repeat (n_entries * 40 + 10 * UART_DIV) @(posedge clk);
        $display("Timeout: the test sequence did not finish in time");
        $display("Checks failed");
        $finish;
    end

    initial begin
        rst_n         = 1'b0;
        ui_in         = 8'h00;
        addr          = 11'h000;
        wdata         = 32'h0;
        write_n       = periph_pkg::ACC_NONE;
        read_n        = periph_pkg::ACC_NONE;
        read_complete = 1'b0;
        checks        = 0;
        errors        = 0;
        grp_errors    = 0;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < n_entries; i++) begin
            case (tbl_op[i])
                OP_WR:   write_word(tbl_addr[i], tbl_data[i]);
                OP_RD:   read_check(tbl_addr[i], tbl_exp[i], 1'b0, 8'h00);
                OP_UI: begin
                    @(posedge clk);
                    ui_in <= tbl_data[i][7:0];
                end
                OP_PIN: begin
                    @(negedge clk);
                    check_value("o_uo_out", {24'h0, uo_out}, tbl_exp[i]);
                end
                OP_UART: run_uart_test(tbl_data[i][7:0]);
                default: read_check(tbl_addr[i], tbl_exp[i], 1'b1, tbl_data[i][7:0]);
            endcase
            if (i == n_entries - 1 || tbl_grp[i + 1] != tbl_grp[i]) begin
                $display("Test %0d %s: %0d errors", tbl_grp[i], test_name(tbl_grp[i]), grp_errors);
                grp_errors = 0;
            end
        end
        assert_errors = dut0.u_assert.error_count;
        $display("Totals: %0d checks, %0d errors, %0d assertion errors",
                 checks, errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
